// File: vlog.f
+incdir+dv
source/console_geom_pkg.sv
source/console_code_pkg.sv
source/char_decoder.sv
source/cursor_writer.sv
source/char_ram.sv
source/frame_reader.sv
source/console_buffer.sv
dv/console_buffer_tb.sv

// File: Bender.yml
package:
  name: console_buffer

sources:
  - files:
      - source/console_geom_pkg.sv
      - source/console_code_pkg.sv
      - source/char_decoder.sv
      - source/cursor_writer.sv
      - source/char_ram.sv
      - source/frame_reader.sv
      - source/console_buffer.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/console_buffer_tb.sv

// File: dv/console_model.svh
// Reference model of the console buffer, included in the testbench top to predict frame data
`ifndef CONSOLE_MODEL_SVH
`define CONSOLE_MODEL_SVH

localparam int RING_CELLS  = console_geom_pkg::BUF_LINES * console_geom_pkg::LINE_WIDTH;
localparam int FRAME_CHARS = console_geom_pkg::SCREEN_LINES * console_geom_pkg::FONT_ROWS *
                             console_geom_pkg::LINE_WIDTH;

logic [7:0] shadow_mem [RING_CELLS];  // Shadow of the line ring
int         m_line;                   // Cursor line
int         m_col;                    // Cursor column
int         m_newlines;               // Line moves since the last clear

// Whole ring blank, cursor home
function automatic void model_clear();
  for (int i = 0; i < RING_CELLS; i++) begin
    shadow_mem[i] = 8'h00;
  end
  m_line     = 0;
  m_col      = 0;
  m_newlines = 0;
endfunction

function automatic void model_blank_at_cursor();
  shadow_mem[m_line * console_geom_pkg::LINE_WIDTH + m_col] = 8'h00;
endfunction

// Next ring line, blanked before use
function automatic void model_next_line();
  m_line = (m_line + 1) % console_geom_pkg::BUF_LINES;
  m_col  = 0;
  m_newlines++;
  for (int c = 0; c < console_geom_pkg::LINE_WIDTH; c++) begin
    shadow_mem[m_line * console_geom_pkg::LINE_WIDTH + c] = 8'h00;
  end
endfunction

function automatic void model_apply(input logic [7:0] ch, input logic alt, input logic [2:0] tab);
  int n;
  n = tab;
  if (alt || ((ch >= 8'd32) && (ch != 8'h7F))) begin  // Stored as is
    shadow_mem[m_line * console_geom_pkg::LINE_WIDTH + m_col] = ch;
    if (m_col == console_geom_pkg::LINE_WIDTH - 1) begin
      model_next_line();
    end else begin
      m_col++;
    end
  end else if (ch == 8'h08) begin
    if (m_col != 0) begin
      m_col--;
    end
    model_blank_at_cursor();  // Erase where the cursor lands
  end else if (ch == 8'h09) begin
    while (n > 0) begin
      model_blank_at_cursor();
      if (m_col == console_geom_pkg::LINE_WIDTH - 1) begin
        model_next_line();
        n = 0;                  // Rest of the tab lost at line end
      end else begin
        m_col++;
        n--;
      end
    end
  end else if ((ch == 8'h0A) || (ch == 8'h0D)) begin
    while (m_col < console_geom_pkg::LINE_WIDTH - 1) begin
      model_blank_at_cursor();
      m_col++;
    end
    model_blank_at_cursor();
    model_next_line();
  end
  // Any other control leaves the buffer alone
endfunction

// Character at position n of the frame stream
function automatic logic [7:0] expected_char(input int n);
  int scr;
  int col;
  int top;
  int line;
  scr  = n / (console_geom_pkg::FONT_ROWS * console_geom_pkg::LINE_WIDTH);
  col  = n % console_geom_pkg::LINE_WIDTH;
  top  = 0;  // Until a full screen of lines is written
  if (m_newlines >= console_geom_pkg::SCREEN_LINES - 1) begin
    top = (m_line - (console_geom_pkg::SCREEN_LINES - 1) + console_geom_pkg::BUF_LINES) %
          console_geom_pkg::BUF_LINES;
  end
  line = (top + scr) % console_geom_pkg::BUF_LINES;
  return shadow_mem[line * console_geom_pkg::LINE_WIDTH + col];
endfunction

`endif

// File: dv/console_buffer_tb.sv
// Testbench top for the console buffer, writes character streams and checks frames against the model
`timescale 1ns/1ns

module console_buffer_tb;

  // Reset clear, five frames (one paused) and about 150 commands take well under 6000 cycles
  localparam int CYCLE_LIMIT = 20000;

  logic        clk;
  logic        rst;
  logic        i_char_stb;
  logic [7:0]  i_char;
  logic        i_alt_func_en;
  logic [2:0]  i_tab_count;
  logic        i_clear_screen_stb;
  logic        o_wr_char_rdy;
  logic        i_read_frame_stb;
  logic        i_char_req_en;
  logic        o_char_rdy;
  logic [7:0]  o_char;

  int          char_count;   // All ready pulses seen
  int          frame_base;   // char_count at frame start
  int          frame_pos;
  int          error_count;  // Wrong characters
  int          fail_count;   // Lost strobes, bad pulse counts, timeout
  int          cycle_count;
  logic [7:0]  exp_ch;
  logic [31:0] rng_state;

  `include "console_model.svh"

  console_buffer u_console_buffer (
    .clk(clk), .rst(rst),
    .i_char_stb(i_char_stb), .i_char(i_char), .i_alt_func_en(i_alt_func_en),
    .i_tab_count(i_tab_count), .i_clear_screen_stb(i_clear_screen_stb),
    .o_wr_char_rdy(o_wr_char_rdy),
    .i_read_frame_stb(i_read_frame_stb), .i_char_req_en(i_char_req_en),
    .o_char_rdy(o_char_rdy), .o_char(o_char)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic finish_with_report(input bit timed_out);
    $display("Compared %0d characters, %0d mismatches, %0d other failures",
             char_count, error_count, fail_count);
    if ((error_count == 0) && (fail_count == 0) && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic wait_ready();
    @(posedge clk);
    while (!o_wr_char_rdy) begin
      @(posedge clk);
    end
  endtask

  task automatic send_char(input logic [7:0] ch, input logic alt, input logic [2:0] tab);
    wait_ready();
    i_char_stb    <= 1'b1;
    i_char        <= ch;
    i_alt_func_en <= alt;
    i_tab_count   <= tab;  // Held until the next command
    @(posedge clk);        // DUT samples the strobe here
    assert (o_wr_char_rdy) else begin
      fail_count++;
      $display("Strobe with code %02h was dropped while ready was low", ch);
    end
    i_char_stb <= 1'b0;
    model_apply(ch, alt, tab);
  endtask

  task automatic clear_screen();
    @(posedge clk);
    i_clear_screen_stb <= 1'b1;
    @(posedge clk);
    i_clear_screen_stb <= 1'b0;
    wait_ready();  // Ready returns once the fill is done
    model_clear();
  endtask

  task automatic read_frame(input bit pause);
    logic [31:0] r;
    wait_ready();
    frame_base       = char_count;
    i_read_frame_stb <= 1'b1;
    i_char_req_en    <= 1'b1;
    @(posedge clk);
    i_read_frame_stb <= 1'b0;
    while (char_count - frame_base < FRAME_CHARS) begin
      if (pause) begin
        r = lcg_next();
        i_char_req_en <= r[31] | r[30];  // Low about a quarter of the time
      end
      @(posedge clk);
    end
    i_char_req_en <= 1'b1;
    repeat (4) @(posedge clk);  // Window for stray pulses
    assert (char_count - frame_base == FRAME_CHARS) else begin
      fail_count++;
      $display("Frame gave %0d ready pulses instead of %0d", char_count - frame_base, FRAME_CHARS);
    end
  endtask

  // Checks every character the reader sends
  always @(posedge clk) begin
    if (!rst && o_char_rdy) begin
      frame_pos = char_count - frame_base;
      if (frame_pos < FRAME_CHARS) begin
        exp_ch = expected_char(frame_pos);
        assert (o_char === exp_ch) else begin
          $display("[ERROR] %0t ns o_char expected %02h actual %02h (frame position %0d)",
                   $time, exp_ch, o_char, frame_pos);
          error_count <= error_count + 1;
        end
      end
      char_count <= char_count + 1;  // Extra pulses caught by the frame count
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the test sequence did not complete", CYCLE_LIMIT);
    fail_count++;
    finish_with_report(1'b1);
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  ch;
    rng_state          = 32'h865977d2;
    rst                = 1'b1;
    i_char_stb         = 1'b0;
    i_char             = 8'h00;
    i_alt_func_en      = 1'b0;
    i_tab_count        = 3'd0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b1;
    model_clear();
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    read_frame(1'b0);  // Blank after the reset clear

    // Printables and backspaces, wraps by column overflow
    for (int i = 0; i < 40; i++) begin
      r  = lcg_next();
      ch = (r[31:29] == 3'd0) ? 8'h08 : 8'd32 + (r[15:8] % 8'd95);
      send_char(ch, 1'b0, 3'd0);
    end
    read_frame(1'b0);

    // CR, LF, tabs and ignored controls among printables
    for (int i = 0; i < 40; i++) begin
      r = lcg_next();
      case (r[31:28])
        4'd0, 4'd1:       ch = 8'h0D;
        4'd2, 4'd3:       ch = 8'h0A;
        4'd4, 4'd5, 4'd6: ch = 8'h09;
        4'd7: begin
          case (r[5:4])
            2'd0:    ch = 8'h01;
            2'd1:    ch = 8'h1B;
            2'd2:    ch = 8'h7F;
            default: ch = 8'h0C;
          endcase
        end
        default:          ch = 8'd32 + (r[15:8] % 8'd95);
      endcase
      send_char(ch, 1'b0, r[2:0]);
    end
    read_frame(1'b0);

    // Enough lines to scroll and wrap the ring
    for (int i = 0; i < 20; i++) begin
      for (int j = 0; j < 3; j++) begin
        r = lcg_next();
        send_char(8'd32 + (r[15:8] % 8'd95), 1'b0, 3'd0);
      end
      send_char(8'h0A, 1'b0, 3'd0);
    end
    send_char(8'h0A, 1'b1, 3'd0);  // Alternate mode stores controls literally
    send_char(8'h08, 1'b1, 3'd0);
    send_char(8'h7F, 1'b1, 3'd0);
    send_char(8'h09, 1'b1, 3'd5);
    send_char(8'h1B, 1'b1, 3'd0);
    read_frame(1'b1);  // Paused scan

    clear_screen();
    read_frame(1'b0);
    finish_with_report(1'b0);
  end

endmodule

// File: source/console_buffer.sv
// Top of the text console character buffer, joins the decoder, cursor writer, memory and frame reader
`timescale 1ns/1ns

module console_buffer (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_char_stb,
  input  logic [7:0] i_char,
  input  logic       i_alt_func_en,
  input  logic [2:0] i_tab_count,
  input  logic       i_clear_screen_stb,
  output logic       o_wr_char_rdy,
  input  logic       i_read_frame_stb,
  input  logic       i_char_req_en,
  output logic       o_char_rdy,
  output logic [7:0] o_char
);

  logic                         cmd_valid;
  console_code_pkg::write_cmd_t cmd;
  logic                         writer_busy;
  logic                         reader_busy;
  logic                         we;
  console_geom_pkg::buf_addr_u  wr_addr;
  logic [7:0]                   wr_data;
  console_geom_pkg::buf_addr_u  rd_addr;
  console_geom_pkg::line_idx_t  top_line;  // First ring line of the frame

  char_decoder u_char_decoder (
    .clk(clk), .rst(rst),
    .i_char_stb(i_char_stb), .i_char(i_char), .i_alt_func_en(i_alt_func_en),
    .i_busy(writer_busy),
    .o_cmd_valid(cmd_valid), .o_cmd(cmd), .o_wr_char_rdy(o_wr_char_rdy)
  );

  cursor_writer u_cursor_writer (
    .clk(clk), .rst(rst),
    .i_cmd_valid(cmd_valid), .i_cmd(cmd), .i_tab_count(i_tab_count),
    .i_clear_screen_stb(i_clear_screen_stb), .i_reader_busy(reader_busy),
    .o_busy(writer_busy), .o_we(we), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
    .o_top_line(top_line)
  );

  char_ram u_char_ram (
    .clk(clk), .i_we(we), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
    .i_rd_addr(rd_addr), .o_rd_data(o_char)
  );

  frame_reader u_frame_reader (
    .clk(clk), .rst(rst),
    .i_read_frame_stb(i_read_frame_stb), .i_char_req_en(i_char_req_en),
    .i_writer_busy(writer_busy), .i_top_line(top_line),
    .o_busy(reader_busy), .o_rd_addr(rd_addr), .o_char_rdy(o_char_rdy)
  );

endmodule

// File: source/frame_reader.sv
// Output side of the console buffer, scans one frame from the ring with each line repeated per font row
`timescale 1ns/1ns

module frame_reader (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_read_frame_stb,
  input  logic                        i_char_req_en,  // Low pauses the scan
  input  logic                        i_writer_busy,
  input  console_geom_pkg::line_idx_t i_top_line,
  output logic                        o_busy,
  output console_geom_pkg::buf_addr_u o_rd_addr,
  output logic                        o_char_rdy
);

  typedef enum logic [2:0] {
    rd_idle,
    rd_wait_writer,
    rd_setup,
    rd_request,
    rd_delay
  } rd_state_e;

  rd_state_e                   state;
  console_geom_pkg::col_idx_t  col;
  logic [$clog2(console_geom_pkg::FONT_ROWS)-1:0]    font_row;
  logic [$clog2(console_geom_pkg::SCREEN_LINES)-1:0] scr_line;  // Offset from top line
  logic                        last_char;
  logic                        req_hit;
  logic                        rdy_d1;  // Matches the memory read latency
  console_geom_pkg::buf_addr_u rd_addr;

  assign req_hit   = (state == rd_request) && i_char_req_en;
  assign o_busy    = (state == rd_setup) || (state == rd_request) || (state == rd_delay);
  assign o_rd_addr = rd_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= rd_idle;
      col        <= '0;
      font_row   <= '0;
      scr_line   <= '0;
      last_char  <= 1'b0;
      rdy_d1     <= 1'b0;
      o_char_rdy <= 1'b0;
    end else begin
      rdy_d1     <= req_hit;
      o_char_rdy <= rdy_d1;
      case (state)
        rd_wait_writer: begin
          if (!i_writer_busy) begin  // Frame starts from a quiet memory
            col       <= '0;
            font_row  <= '0;
            scr_line  <= '0;
            last_char <= 1'b0;
            state     <= rd_setup;
          end
        end
        rd_setup: state <= rd_request;
        rd_request: begin
          if (i_char_req_en) begin
            col <= col + 1'b1;
            if (col == console_geom_pkg::LINE_WIDTH - 1) begin
              if (font_row == console_geom_pkg::FONT_ROWS - 1) begin
                font_row  <= '0;
                scr_line  <= scr_line + 1'b1;
                last_char <= (scr_line == console_geom_pkg::SCREEN_LINES - 1);
              end else begin
                font_row  <= font_row + 1'b1;  // Same line again
              end
            end
            state <= rd_delay;
          end
        end
        rd_delay: state <= last_char ? rd_idle : rd_request;
        default:  state <= rd_idle;
      endcase
      if (i_read_frame_stb) begin
        state <= rd_wait_writer;  // Restart from the top
      end
    end
  end

  // Address of the requested character
  always_ff @(posedge clk) begin
    if (req_hit) begin
      rd_addr.lc.line <= i_top_line + console_geom_pkg::line_idx_t'(scr_line);
      rd_addr.lc.col  <= col;
    end
  end

  a_rdy_single: assert property (@(posedge clk) disable iff (rst) o_char_rdy |=> !o_char_rdy);

endmodule

// File: source/char_ram.sv
// Character store of the console buffer, one write port and one registered read port
`timescale 1ns/1ns

module char_ram (
  input  logic                        clk,
  input  logic                        i_we,
  input  console_geom_pkg::buf_addr_u i_wr_addr,
  input  logic [7:0]                  i_wr_data,
  input  console_geom_pkg::buf_addr_u i_rd_addr,
  output logic [7:0]                  o_rd_data
);

  logic [7:0] mem [2**console_geom_pkg::ADDR_BITS];  // Whole line ring

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_wr_addr.flat] <= i_wr_data;
    end
  end

  // Data appears one cycle after the address
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr.flat];
  end

endmodule

// File: source/cursor_writer.sv
// Processing part of the console buffer, runs the write FSM and tracks the frame top line
`timescale 1ns/1ns

module cursor_writer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_cmd_valid,
  input  console_code_pkg::write_cmd_t  i_cmd,
  input  logic [2:0]                    i_tab_count,
  input  logic                          i_clear_screen_stb,
  input  logic                          i_reader_busy,
  output logic                          o_busy,
  output logic                          o_we,
  output console_geom_pkg::buf_addr_u   o_wr_addr,
  output logic [7:0]                    o_wr_data,
  output console_geom_pkg::line_idx_t   o_top_line
);

  typedef enum logic [2:0] {
    st_idle,
    st_print,
    st_backspace,
    st_pad_line,    // Blank the rest of the old line
    st_clear_line,  // Blank the whole new line
    st_tab,
    st_clear_all
  } wr_state_e;

  wr_state_e                   state;
  console_geom_pkg::buf_addr_u cur;  // Cursor, also the clear-all counter
  logic [7:0]                  wr_ch;
  logic [$clog2(console_geom_pkg::MAX_TAB+1)-1:0]  tab_cnt;
  logic                        clear_req;
  logic [$clog2(console_geom_pkg::SCREEN_LINES)-1:0] lines_used;  // Saturates one short of a screen
  console_geom_pkg::line_idx_t top_line;
  logic                        col_last;
  logic                        new_line;

  assign col_last = (cur.lc.col == console_geom_pkg::LINE_WIDTH - 1);

  // Leaving the last column moves to the next ring line
  assign new_line = col_last && ((state == st_print) || (state == st_pad_line) ||
                                 ((state == st_tab) && (tab_cnt != '0)));

  // A pending clear counts as busy unless a command is being taken this cycle
  assign o_busy     = (state != st_idle) || (clear_req && !i_cmd_valid);
  assign o_we       = (state == st_print) || (state == st_backspace) || (state == st_pad_line) ||
                      (state == st_clear_line) || (state == st_clear_all) ||
                      ((state == st_tab) && (tab_cnt != '0));
  assign o_wr_addr  = cur;
  assign o_wr_data  = (state == st_print) ? wr_ch : console_code_pkg::BLANK_CHAR;
  assign o_top_line = top_line;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_clear_all;  // Memory is wiped after reset
      cur       <= '0;
      tab_cnt   <= '0;
      clear_req <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (i_cmd_valid) begin
            tab_cnt <= i_tab_count;
            case (i_cmd.op)
              console_code_pkg::op_print:   state <= st_print;
              console_code_pkg::op_backspace: begin
                if (cur.lc.col != '0) begin
                  cur.lc.col <= cur.lc.col - 1'b1;  // Step back, then erase there
                end
                state <= st_backspace;
              end
              console_code_pkg::op_newline: state <= st_pad_line;
              console_code_pkg::op_tab:     state <= st_tab;
              default:                      state <= st_idle;
            endcase
          end else if (clear_req && !i_reader_busy) begin
            clear_req <= 1'b0;
            cur       <= '0;
            state     <= st_clear_all;
          end
        end
        st_print: begin
          cur.lc.col <= cur.lc.col + 1'b1;
          state      <= st_idle;
        end
        st_backspace:  state <= st_idle;
        st_pad_line:   cur.lc.col <= cur.lc.col + 1'b1;  // Ends through new_line
        st_clear_line: begin
          cur.lc.col <= cur.lc.col + 1'b1;  // Wraps back to column 0
          if (col_last) begin
            state <= st_idle;
          end
        end
        st_tab: begin
          if (tab_cnt == '0) begin
            state <= st_idle;
          end else begin
            tab_cnt    <= tab_cnt - 1'b1;
            cur.lc.col <= cur.lc.col + 1'b1;
          end
        end
        st_clear_all: begin
          cur.flat <= cur.flat + 1'b1;  // Ends back at home
          if ((cur.lc.line == console_geom_pkg::BUF_LINES - 1) && col_last) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase

      // Remaining tab blanks are dropped at the line end
      if (new_line) begin
        cur.lc.line <= cur.lc.line + 1'b1;
        cur.lc.col  <= '0;
        state       <= st_clear_line;
      end

      if (i_clear_screen_stb) begin
        clear_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_idle) && i_cmd_valid) begin
      wr_ch <= i_cmd.ch;
    end
  end

  // Frame top trails the cursor line once a full screen is in use
  always_ff @(posedge clk) begin
    if (rst || (state == st_clear_all)) begin
      lines_used <= '0;
      top_line   <= '0;
    end else if (new_line) begin
      if (lines_used == console_geom_pkg::SCREEN_LINES - 1) begin
        top_line <= top_line + 1'b1;
      end else begin
        lines_used <= lines_used + 1'b1;
      end
    end
  end

  // Memory fill never runs under a frame scan
  a_clear_reader_idle: assert property (@(posedge clk) disable iff (rst)
    (state == st_clear_all) |-> !i_reader_busy);
  // Cursor line stays inside the frame below the top line
  a_cursor_on_screen: assert property (@(posedge clk) disable iff (rst)
    (state != st_clear_all) |->
      (console_geom_pkg::line_idx_t'(cur.lc.line - top_line) < console_geom_pkg::SCREEN_LINES));

endmodule

// File: source/char_decoder.sv
// Input side of the console buffer, turns a character strobe into a registered write command
`timescale 1ns/1ns

module char_decoder (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_char_stb,
  input  logic [7:0]                  i_char,
  input  logic                        i_alt_func_en,  // Store any code literally
  input  logic                        i_busy,         // Writer not ready
  output logic                        o_cmd_valid,
  output console_code_pkg::write_cmd_t o_cmd,
  output logic                        o_wr_char_rdy
);

  console_code_pkg::write_cmd_t dec_cmd;
  logic                         dec_keep;  // Code maps to a command
  logic                         accept;

  // Classify the incoming code
  always_comb begin
    dec_cmd.ch = i_char;
    dec_cmd.op = console_code_pkg::op_print;
    dec_keep   = 1'b1;
    if (!i_alt_func_en) begin
      case (i_char)
        console_code_pkg::BS_CODE: dec_cmd.op = console_code_pkg::op_backspace;
        console_code_pkg::HT_CODE: dec_cmd.op = console_code_pkg::op_tab;
        console_code_pkg::LF_CODE,
        console_code_pkg::CR_CODE: dec_cmd.op = console_code_pkg::op_newline;
        default: begin
          // Remaining controls are dropped
          if ((i_char < console_code_pkg::CTRL_LIMIT) || (i_char == console_code_pkg::DEL_CODE)) begin
            dec_keep = 1'b0;
          end
        end
      endcase
    end
  end

  assign o_wr_char_rdy = !i_busy && !o_cmd_valid;  // Low while a command is in flight
  assign accept        = i_char_stb && o_wr_char_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cmd_valid <= 1'b0;
    end else begin
      o_cmd_valid <= accept && dec_keep;  // One-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_cmd <= dec_cmd;
    end
  end

  // Writer must be idle whenever a command is handed over
  a_cmd_not_busy: assert property (@(posedge clk) disable iff (rst) !(o_cmd_valid && i_busy));

endmodule

// File: source/console_code_pkg.sv
// Character codes and the write command passed from the input decoder to the cursor writer
package console_code_pkg;

  // Control codes that the console acts on
  localparam logic [7:0] BS_CODE    = 8'h08;  // Backspace
  localparam logic [7:0] HT_CODE    = 8'h09;  // Horizontal tab
  localparam logic [7:0] LF_CODE    = 8'h0A;  // Line feed
  localparam logic [7:0] CR_CODE    = 8'h0D;  // Carriage return
  localparam logic [7:0] DEL_CODE   = 8'h7F;  // Also treated as control

  localparam logic [7:0] CTRL_LIMIT = 8'd32;  // Codes below are controls
  localparam logic [7:0] BLANK_CHAR = 8'h00;  // Fill value for cleared cells

  // What the writer does with a command
  typedef enum logic [2:0] {
    op_print,
    op_backspace,
    op_newline,    // CR and LF alike
    op_tab
  } write_op_e;

  // One accepted character
  typedef struct packed {
    write_op_e  op;
    logic [7:0] ch;
  } write_cmd_t;

endpackage

// File: source/console_geom_pkg.sv
// Screen, ring buffer and address definitions shared by the console buffer writer, reader and memory
package console_geom_pkg;

  // Visible screen
  localparam int LINE_WIDTH   = 16;  // Characters per text line
  localparam int SCREEN_LINES = 4;   // Text lines shown per frame
  localparam int FONT_ROWS    = 2;   // Each line is sent once per pixel row

  // Ring memory
  localparam int BUF_LINES    = 16;
  localparam int COL_BITS     = 4;
  localparam int LINE_BITS    = 4;
  localparam int ADDR_BITS    = 8;   // LINE_BITS + COL_BITS

  localparam int MAX_TAB      = 7;   // Largest blank count for one tab

  typedef logic [LINE_BITS-1:0] line_idx_t;  // Line in the ring
  typedef logic [COL_BITS-1:0]  col_idx_t;   // Column within a line

  // Line in the upper bits, column in the lower bits
  typedef struct packed {
    line_idx_t line;
    col_idx_t  col;
  } line_col_t;

  // Same word seen by the memory as a flat address
  typedef union packed {
    logic [ADDR_BITS-1:0] flat;
    line_col_t            lc;
  } buf_addr_u;

endpackage
